// ==== verilog/cpu_defines.svh ====
// Shared widths and sizes for the microcoded CPU
// IDB, control store, register file and page table dimensions
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Internal data bus and register width
`define WORD_W 16

// Control store geometry
`define CS_WORD_W 64   // Full microword
`define CS_ADDR_W 10   // 1024 microwords
`define CS_PART_W 2    // Selects one of four 16-bit parts

// Register file
`define REG_SEL_W 3    // 8 general registers

// Memory management
`define LPAGE_W 6      // 64 page table entries
`define PPN_W 14       // Physical page number
`define PT_VALID_BIT 15  // Entry valid flag in a page table write

`endif

// ==== verilog/cpu_pkg.sv ====
// Microword layout and opcode encodings for the microprogram engine
// Both microword views share the format and halt bits at the top
`include "cpu_defines.svh"

package cpu_pkg;

  typedef enum logic [2:0] {
    ALU_LOAD,  // Result = operand
    ALU_ADD,   // Dst + operand
    ALU_SUB,   // Dst - operand
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHL,   // Operand << 1
    ALU_SHR    // Operand >> 1, logical
  } alu_op_e;

  typedef enum logic [1:0] {
    JMP_ALWAYS,
    JMP_ZERO,     // Last ALU result was zero
    JMP_NONZERO,
    JMP_NEG       // Last ALU result had MSB set
  } jump_cond_e;

  typedef struct packed {
    logic                  fmt;      // 0 here, bit 63
    logic                  halt;     // Stop after this word
    logic                  emit;     // Put result on IDB
    alu_op_e               op;
    logic [`REG_SEL_W-1:0] dst;
    logic [`REG_SEL_W-1:0] src;
    logic                  use_imm;  // Operand from imm, not src
    logic [`WORD_W-1:0]    imm;
    logic [`CS_WORD_W-2*`REG_SEL_W-`WORD_W-8:0] spare;
  } alu_word_s;

  typedef struct packed {
    logic                  fmt;      // 1 here
    logic                  halt;
    jump_cond_e            cond;
    logic [`CS_ADDR_W-1:0] target;
    logic [`CS_WORD_W-`CS_ADDR_W-5:0] spare;
  } jump_word_s;

  // Same 64 bits, decoded by the format bit
  typedef union packed {
    alu_word_s  alu;
    jump_word_s jmp;
  } cs_word_u;

endpackage

// ==== verilog/cs_fetch_if.sv ====
// Microword fetch path between the engine and the control store
// Word and its valid strobe follow a fetch by one cycle
`include "cpu_defines.svh"

interface cs_fetch_if
  import cpu_pkg::*;
();

  logic                  fetch;       // Single-cycle request
  logic [`CS_ADDR_W-1:0] addr;        // Microword address
  logic                  word_valid;  // Word returned
  cs_word_u              word;

  modport engine (
    output fetch, addr,
    input  word_valid, word
  );

  modport store (
    input  fetch, addr,
    output word_valid, word
  );

endinterface

// ==== verilog/control_store.sv ====
// Writable control store holding 64-bit microwords
// Host writes and reads back 16-bit parts over the IDB, engine fetches whole words
`include "cpu_defines.svh"

module control_store (
  input  logic                  sysclk,
  input  logic                  reset,
  input  logic                  wcs_wr,     // Host part write
  input  logic                  wcs_rd,     // Host part readback
  input  logic [`CS_ADDR_W-1:0] wcs_addr,
  input  logic [`CS_PART_W-1:0] wcs_part,   // Which 16 bits of the word
  input  logic [`WORD_W-1:0]    idb_in,
  output logic [`WORD_W-1:0]    idb_out,    // Zero unless readback, wired-OR
  output logic                  idb_valid,
  cs_fetch_if.store             fetch_port
);

  localparam int CS_DEPTH = 1 << `CS_ADDR_W;

  logic [`CS_WORD_W-1:0] cs_mem [CS_DEPTH];  // Microword RAM
  logic [`WORD_W-1:0]    rd_data;            // Readback part

  // Host load, one part per strobe, visible next cycle
  always_ff @(posedge sysclk) begin
    if (wcs_wr) begin
      cs_mem[wcs_addr][wcs_part*`WORD_W +: `WORD_W] <= idb_in;
    end
  end

  // Readback data capture
  always_ff @(posedge sysclk) begin
    if (wcs_rd) begin
      rd_data <= cs_mem[wcs_addr][wcs_part*`WORD_W +: `WORD_W];
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      idb_valid <= 1'b0;
    end else begin
      idb_valid <= wcs_rd;  // One cycle after request
    end
  end

  assign idb_out = idb_valid ? rd_data : '0;  // Idle source drives zero

  // Engine fetch port
  always_ff @(posedge sysclk) begin
    if (fetch_port.fetch) begin
      fetch_port.word <= cs_mem[fetch_port.addr];  // Whole microword
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      fetch_port.word_valid <= 1'b0;
    end else begin
      fetch_port.word_valid <= fetch_port.fetch;  // Fixed 1-cycle latency
    end
  end

endmodule

// ==== verilog/micro_engine.sv ====
// Microprogram engine with PC, 8 x 16-bit register file and ALU
// Runs fetch/execute pairs from start_addr until a halt word, emits results on IDB
`include "cpu_defines.svh"

module micro_engine
  import cpu_pkg::*;
(
  input  logic                  sysclk,
  input  logic                  reset,
  input  logic                  start,       // Ignored while busy
  input  logic [`CS_ADDR_W-1:0] start_addr,
  cs_fetch_if.engine            fetch_port,
  output logic [`WORD_W-1:0]    idb_out,     // Zero unless emitting
  output logic                  idb_valid,
  output logic                  busy,
  output logic                  done         // One cycle after halt word
);

  localparam int NUM_REGS = 1 << `REG_SEL_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,  // Fetch strobe out
    ST_EXEC    // Word arrives, execute
  } eng_state_e;

  eng_state_e            state;
  logic [`CS_ADDR_W-1:0] pc;                // Microprogram counter
  logic [`WORD_W-1:0]    regs [NUM_REGS];
  logic                  zero_flag;
  logic                  neg_flag;
  cs_word_u              uword;             // Current microword
  logic                  exec;
  logic [`WORD_W-1:0]    operand;
  logic [`WORD_W-1:0]    dst_val;
  logic [`WORD_W-1:0]    alu_result;
  logic                  take_jump;
  logic [`CS_ADDR_W-1:0] next_pc;
  logic [`WORD_W-1:0]    emit_data;

  assign uword            = fetch_port.word;
  assign exec             = (state == ST_EXEC) && fetch_port.word_valid;
  assign fetch_port.fetch = (state == ST_FETCH);
  assign fetch_port.addr  = pc;
  assign busy             = (state != ST_IDLE);

  // ALU on the ALU view of the word
  always_comb begin
    operand = uword.alu.use_imm ? uword.alu.imm : regs[uword.alu.src];
    dst_val = regs[uword.alu.dst];
    case (uword.alu.op)
      ALU_LOAD: alu_result = operand;
      ALU_ADD:  alu_result = dst_val + operand;
      ALU_SUB:  alu_result = dst_val - operand;
      ALU_AND:  alu_result = dst_val & operand;
      ALU_OR:   alu_result = dst_val | operand;
      ALU_XOR:  alu_result = dst_val ^ operand;
      ALU_SHL:  alu_result = {operand[`WORD_W-2:0], 1'b0};
      ALU_SHR:  alu_result = {1'b0, operand[`WORD_W-1:1]};
      default:  alu_result = operand;
    endcase
  end

  // Branch decision on the jump view, flags from last ALU result
  always_comb begin
    case (uword.jmp.cond)
      JMP_ALWAYS:  take_jump = 1'b1;
      JMP_ZERO:    take_jump = zero_flag;
      JMP_NONZERO: take_jump = !zero_flag;
      JMP_NEG:     take_jump = neg_flag;
      default:     take_jump = 1'b0;
    endcase
    next_pc = (uword.jmp.fmt && take_jump) ? uword.jmp.target : pc + 1'b1;  // Wraps
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      state     <= ST_IDLE;
      pc        <= '0;
      zero_flag <= 1'b0;
      neg_flag  <= 1'b0;
      done      <= 1'b0;
      idb_valid <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      done      <= 1'b0;  // Strobes
      idb_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            pc    <= start_addr;
            state <= ST_FETCH;  // First fetch next cycle
          end
        end
        ST_FETCH: state <= ST_EXEC;
        ST_EXEC: begin
          if (exec) begin
            pc    <= next_pc;
            state <= uword.alu.halt ? ST_IDLE : ST_FETCH;
            done  <= uword.alu.halt;  // Halt bit common to both views
            if (!uword.alu.fmt) begin
              regs[uword.alu.dst] <= alu_result;
              zero_flag           <= (alu_result == '0);
              neg_flag            <= alu_result[`WORD_W-1];
              idb_valid           <= uword.alu.emit;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Emit data register
  always_ff @(posedge sysclk) begin
    if (exec && !uword.alu.fmt && uword.alu.emit) begin
      emit_data <= alu_result;
    end
  end

  assign idb_out = idb_valid ? emit_data : '0;  // Wired-OR source

endmodule

// ==== verilog/mmu_page_table.sv ====
// Memory management page table
// Maps a logical page to a PPN with fault on invalid entry, passthrough with protection off
`include "cpu_defines.svh"

module mmu_page_table (
  input  logic                sysclk,
  input  logic                reset,
  input  logic                pt_wr,       // Page table entry write
  input  logic [`LPAGE_W-1:0] pt_index,
  input  logic [`WORD_W-1:0]  idb_in,      // PPN and valid flag
  input  logic                xlat,        // Translate request
  input  logic [`PPN_W-1:0]   la_page,     // Logical page
  input  logic                poni,        // Memory protection on
  output logic [`PPN_W-1:0]   ppn,
  output logic                ppn_valid,
  output logic                page_fault
);

  localparam int PT_DEPTH = 1 << `LPAGE_W;

  logic [`PPN_W-1:0]   pt_ppn [PT_DEPTH];  // Stored physical pages
  logic [PT_DEPTH-1:0] pt_valid;           // Entry valid flags
  logic [`LPAGE_W-1:0] xlat_index;
  logic                entry_valid;

  assign xlat_index  = la_page[`LPAGE_W-1:0];  // Low bits select the entry
  assign entry_valid = pt_valid[xlat_index];

  always_ff @(posedge sysclk) begin
    if (pt_wr) begin
      pt_ppn[pt_index] <= idb_in[`PPN_W-1:0];
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      pt_valid <= '0;  // All entries invalid
    end else if (pt_wr) begin
      pt_valid[pt_index] <= idb_in[`PT_VALID_BIT];
    end
  end

  // Translation result one cycle after xlat
  always_ff @(posedge sysclk) begin
    if (xlat) begin
      if (poni) begin
        ppn <= entry_valid ? pt_ppn[xlat_index] : '0;  // Zero on fault
      end else begin
        ppn <= la_page;  // Direct logical-to-physical
      end
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      ppn_valid  <= 1'b0;
      page_fault <= 1'b0;
    end else begin
      ppn_valid  <= xlat;
      page_fault <= xlat && poni && !entry_valid;
    end
  end

endmodule

// ==== verilog/cpu_top.sv ====
// CPU top level with control store, microprogram engine and page table
// Readback and emit sources share the IDB as a wired-OR
`include "cpu_defines.svh"

module cpu_top (
  input  logic                  sysclk,
  input  logic                  reset,
  input  logic                  wcs_wr,
  input  logic                  wcs_rd,
  input  logic [`CS_ADDR_W-1:0] wcs_addr,
  input  logic [`CS_PART_W-1:0] wcs_part,
  input  logic [`WORD_W-1:0]    idb_in,
  input  logic                  pt_wr,
  input  logic [`LPAGE_W-1:0]   pt_index,
  input  logic                  xlat,
  input  logic [`PPN_W-1:0]     la_page,
  input  logic                  poni,
  input  logic                  start,
  input  logic [`CS_ADDR_W-1:0] start_addr,
  output logic [`WORD_W-1:0]    idb_out,
  output logic                  idb_valid,
  output logic                  busy,
  output logic                  done,
  output logic [`PPN_W-1:0]     ppn,
  output logic                  ppn_valid,
  output logic                  page_fault
);

  logic [`WORD_W-1:0] cs_idb_out;    // Control store readback
  logic               cs_idb_valid;
  logic [`WORD_W-1:0] proc_idb_out;  // Engine emit
  logic               proc_idb_valid;

  cs_fetch_if fetch_bus ();  // Engine to store fetch path

  control_store cs (
    .sysclk     (sysclk),
    .reset      (reset),
    .wcs_wr     (wcs_wr),
    .wcs_rd     (wcs_rd),
    .wcs_addr   (wcs_addr),
    .wcs_part   (wcs_part),
    .idb_in     (idb_in),
    .idb_out    (cs_idb_out),
    .idb_valid  (cs_idb_valid),
    .fetch_port (fetch_bus.store)
  );

  micro_engine proc (
    .sysclk     (sysclk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .fetch_port (fetch_bus.engine),
    .idb_out    (proc_idb_out),
    .idb_valid  (proc_idb_valid),
    .busy       (busy),
    .done       (done)
  );

  mmu_page_table mmu (
    .sysclk     (sysclk),
    .reset      (reset),
    .pt_wr      (pt_wr),
    .pt_index   (pt_index),
    .idb_in     (idb_in),
    .xlat       (xlat),
    .la_page    (la_page),
    .poni       (poni),
    .ppn        (ppn),
    .ppn_valid  (ppn_valid),
    .page_fault (page_fault)
  );

  // Idle sources drive zero, so OR forms the bus
  assign idb_out   = cs_idb_out | proc_idb_out;
  assign idb_valid = cs_idb_valid | proc_idb_valid;

endmodule

// ==== testbench/cpu_tb.sv ====
// Testbench for the microcoded CPU top level
// Directed tests of control store access, microprograms and page translation
`include "cpu_defines.svh"

module cpu_tb
  import cpu_pkg::*;
();

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_BUDGET = 400;  // Cycles for the worst single test
  localparam int WAIT_LIMIT  = 100;  // Cycles allowed for any strobe

  logic                  sysclk;
  logic                  reset;
  logic                  wcs_wr;
  logic                  wcs_rd;
  logic [`CS_ADDR_W-1:0] wcs_addr;
  logic [`CS_PART_W-1:0] wcs_part;
  logic [`WORD_W-1:0]    idb_in;
  logic                  pt_wr;
  logic [`LPAGE_W-1:0]   pt_index;
  logic                  xlat;
  logic [`PPN_W-1:0]     la_page;
  logic                  poni;
  logic                  start;
  logic [`CS_ADDR_W-1:0] start_addr;
  logic [`WORD_W-1:0]    idb_out;
  logic                  idb_valid;
  logic                  busy;
  logic                  done;
  logic [`PPN_W-1:0]     ppn;
  logic                  ppn_valid;
  logic                  page_fault;
  logic [15:0]           lfsr_state = 16'd38759;  // Seed

  cpu_top dut (.*);

  initial begin
    sysclk = 1'b0;
    forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
  end

  // Whole run bounded by test count times worst test length
  initial begin
    #(NUM_TESTS * TEST_BUDGET * CLK_PERIOD);
    abort_run("Watchdog expired before all tests finished");
  end

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  // Taps of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic cs_word_u alu_word(logic halt, logic emit, alu_op_e op,
                                        logic [2:0] dst, logic [2:0] src,
                                        logic use_imm, logic [`WORD_W-1:0] imm);
    cs_word_u w;
    w             = '0;  // Clears fmt and spare bits
    w.alu.halt    = halt;
    w.alu.emit    = emit;
    w.alu.op      = op;
    w.alu.dst     = dst;
    w.alu.src     = src;
    w.alu.use_imm = use_imm;
    w.alu.imm     = imm;
    return w;
  endfunction

  function automatic cs_word_u jump_word(jump_cond_e cond, logic [`CS_ADDR_W-1:0] target);
    cs_word_u w;
    w            = '0;
    w.jmp.fmt    = 1'b1;
    w.jmp.cond   = cond;
    w.jmp.target = target;
    return w;
  endfunction

  task automatic write_part(logic [`CS_ADDR_W-1:0] addr, logic [1:0] part,
                            logic [`WORD_W-1:0] data);
    @(posedge sysclk);
    wcs_wr   <= 1'b1;
    wcs_addr <= addr;
    wcs_part <= part;
    idb_in   <= data;
    @(posedge sysclk);
    wcs_wr <= 1'b0;
  endtask

  task automatic read_part(logic [`CS_ADDR_W-1:0] addr, logic [1:0] part,
                           output logic [`WORD_W-1:0] data);
    @(posedge sysclk);
    wcs_rd   <= 1'b1;
    wcs_addr <= addr;
    wcs_part <= part;
    @(posedge sysclk);
    wcs_rd <= 1'b0;
    @(negedge sysclk);  // Readback cycle
    check("idb_valid", 1, idb_valid);
    data = idb_out;
  endtask

  task automatic load_word(logic [`CS_ADDR_W-1:0] addr, cs_word_u w);
    logic [`CS_WORD_W-1:0] bits;
    bits = w;
    for (int p = 0; p < 4; p++) begin
      write_part(addr, p[1:0], bits[p*`WORD_W +: `WORD_W]);  // Low part first
    end
  endtask

  task automatic pulse_start(logic [`CS_ADDR_W-1:0] addr);
    @(posedge sysclk);
    start      <= 1'b1;
    start_addr <= addr;
    @(posedge sysclk);
    start <= 1'b0;
  endtask

  task automatic wait_emit(output logic [`WORD_W-1:0] data);
    int n;
    n = 0;
    @(negedge sysclk);
    while (!idb_valid) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("Emit strobe on idb_valid never came");
      @(negedge sysclk);
    end
    data = idb_out;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    @(negedge sysclk);
    while (!done) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("Engine never strobed done");
      @(negedge sysclk);
    end
  endtask

  task automatic write_entry(logic [`LPAGE_W-1:0] index, logic valid, logic [`PPN_W-1:0] page);
    @(posedge sysclk);
    pt_wr    <= 1'b1;
    pt_index <= index;
    idb_in   <= {valid, 1'b0, page};  // Valid flag at bit 15
    @(posedge sysclk);
    pt_wr <= 1'b0;
  endtask

  task automatic translate(logic [`PPN_W-1:0] page, logic prot_on);
    @(posedge sysclk);
    xlat    <= 1'b1;
    la_page <= page;
    poni    <= prot_on;
    @(posedge sysclk);
    xlat <= 1'b0;
    @(negedge sysclk);  // Result cycle
    check("ppn_valid", 1, ppn_valid);
  endtask

  task automatic check_reset_state();
    @(negedge sysclk);
    check("idb_valid", 0, idb_valid);
    check("busy", 0, busy);
    check("done", 0, done);
    check("ppn_valid", 0, ppn_valid);
    check("page_fault", 0, page_fault);
    translate(take_bits(`PPN_W), 1'b1);  // Every entry invalid
    check("page_fault", 1, page_fault);
    check("ppn", 0, ppn);
  endtask

  task automatic cs_write_readback();
    logic [`CS_ADDR_W-1:0] addr [4];
    logic [`WORD_W-1:0]    parts [4][4];
    logic [`WORD_W-1:0]    data;
    for (int a = 0; a < 4; a++) begin
      addr[a] = (a << (`CS_ADDR_W - 2)) | take_bits(`CS_ADDR_W - 2);  // Top bits differ
      for (int p = 0; p < 4; p++) begin
        parts[a][p] = take_bits(`WORD_W);
        write_part(addr[a], p[1:0], parts[a][p]);
      end
    end
    for (int a = 0; a < 4; a++) begin
      for (int p = 0; p < 4; p++) begin
        read_part(addr[a], p[1:0], data);
        check("idb_out", parts[a][p], data);
      end
    end
  endtask

  task automatic straight_line_program();
    logic [`WORD_W-1:0] a;
    logic [`WORD_W-1:0] b;
    logic [`WORD_W-1:0] r1;
    logic [`WORD_W-1:0] r2;
    logic [`WORD_W-1:0] want [6];
    logic [`WORD_W-1:0] data;
    a = take_bits(`WORD_W);
    b = take_bits(`WORD_W);
    load_word(10'd0, alu_word(1'b0, 1'b1, ALU_LOAD, 3'd1, 3'd0, 1'b1, a));
    load_word(10'd1, alu_word(1'b0, 1'b1, ALU_LOAD, 3'd2, 3'd0, 1'b1, b));
    load_word(10'd2, alu_word(1'b0, 1'b1, ALU_ADD, 3'd1, 3'd2, 1'b0, '0));  // r1 += r2
    load_word(10'd3, alu_word(1'b0, 1'b1, ALU_SUB, 3'd2, 3'd1, 1'b0, '0));  // r2 -= r1
    load_word(10'd4, alu_word(1'b0, 1'b1, ALU_XOR, 3'd1, 3'd2, 1'b0, '0));  // r1 ^= r2
    load_word(10'd5, alu_word(1'b0, 1'b1, ALU_SHL, 3'd3, 3'd1, 1'b0, '0));  // r3 = r1 << 1
    load_word(10'd6, alu_word(1'b1, 1'b0, ALU_AND, 3'd0, 3'd0, 1'b1, '0));  // Halt without emit
    r1      = a + b;
    r2      = b - r1;
    want[0] = a;
    want[1] = b;
    want[2] = r1;
    want[3] = r2;
    r1      = r1 ^ r2;
    want[4] = r1;
    want[5] = r1 << 1;
    pulse_start(10'd0);
    for (int i = 0; i < 6; i++) begin
      wait_emit(data);
      check("idb_out", want[i], data);
    end
    wait_done();
    check("busy", 0, busy);
  endtask

  task automatic countdown_loop();
    logic [`CS_ADDR_W-1:0] base;
    logic [`WORD_W-1:0]    n;
    logic [`WORD_W-1:0]    data;
    base = 10'h200;
    n    = take_bits(3) + 1;  // 1 to 8
    load_word(base, alu_word(1'b0, 1'b0, ALU_LOAD, 3'd4, 3'd0, 1'b1, n));
    load_word(base + 1, alu_word(1'b0, 1'b1, ALU_SUB, 3'd4, 3'd0, 1'b1, 16'd1));
    load_word(base + 2, jump_word(JMP_NONZERO, base + 1));
    load_word(base + 3, alu_word(1'b1, 1'b0, ALU_AND, 3'd0, 3'd0, 1'b1, '0));
    pulse_start(base);
    @(negedge sysclk);
    check("busy", 1, busy);
    pulse_start(10'd0);  // Must be ignored
    for (int i = 1; i <= n; i++) begin
      wait_emit(data);
      check("idb_out", n - i, data);
    end
    wait_done();
    check("busy", 0, busy);
  endtask

  task automatic mapped_translation();
    logic [`LPAGE_W-1:0] index [8];
    logic                entry_valid [1 << `LPAGE_W];
    logic [`PPN_W-1:0]   entry_page [1 << `LPAGE_W];
    for (int i = 0; i < 8; i++) begin
      index[i]              = take_bits(`LPAGE_W);
      entry_valid[index[i]] = i[0];  // Every other entry left invalid
      entry_page[index[i]]  = take_bits(`PPN_W);
      write_entry(index[i], entry_valid[index[i]], entry_page[index[i]]);
    end
    for (int i = 0; i < 8; i++) begin
      translate({take_bits(`PPN_W - `LPAGE_W), index[i]}, 1'b1);  // High bits ignored
      check("page_fault", !entry_valid[index[i]], page_fault);
      check("ppn", entry_valid[index[i]] ? entry_page[index[i]] : '0, ppn);
    end
  endtask

  task automatic protection_off();
    logic [`PPN_W-1:0] page;
    for (int i = 0; i < 8; i++) begin
      page = take_bits(`PPN_W);
      translate(page, 1'b0);
      check("page_fault", 0, page_fault);
      check("ppn", page, ppn);
    end
  endtask

  initial begin
    reset      = 1'b1;
    wcs_wr     = 1'b0;
    wcs_rd     = 1'b0;
    wcs_addr   = '0;
    wcs_part   = '0;
    idb_in     = '0;
    pt_wr      = 1'b0;
    pt_index   = '0;
    xlat       = 1'b0;
    la_page    = '0;
    poni       = 1'b0;
    start      = 1'b0;
    start_addr = '0;
    repeat (16) @(posedge sysclk);
    reset <= 1'b0;
    check_reset_state();
    cs_write_readback();
    straight_line_program();
    countdown_loop();
    mapped_translation();
    protection_off();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cs_fetch_if.sv
verilog/control_store.sv
verilog/micro_engine.sv
verilog/mmu_page_table.sv
verilog/cpu_top.sv
testbench/cpu_tb.sv

// ==== Makefile ====
# Verilator simulation of the microcoded CPU testbench
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and sim.log"
	@echo "  help   show this list"

obj_dir/Vcpu_tb: files.f $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
	verilator --binary -Wno-fatal -f files.f --top-module cpu_tb -o Vcpu_tb

test: obj_dir/Vcpu_tb
	-./obj_dir/Vcpu_tb > sim.log 2>&1
	@cat sim.log
	@grep -q "^\*\*\* PASSED \*\*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log
